// ==== hdl/cpu_cfg.svh ====
// CPU build constants
// register count, minimum state length and bus alarm delay

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// r0 holds the flags, r1..r7 are general registers
`define CPU_REGS 8

// minimum clocks in every machine state, the stand-in for strobe widths
// values below 1 are not meaningful
`define CPU_STATE_TICKS 2

// clocks of a raised strobe without ok before the bus alarm
`define CPU_ALARM_TICKS 64

`endif

// ==== hdl/cpu_pkg.sv ====
// CPU shared types
// word, instruction formats and union, opcodes, ALU operations,
// flags, decoder control, machine states and bus request

package cpu_pkg;

	typedef logic [0:15] word_t; // bit 0 is the msb, as on the bus

	// bit 0 of the opcode picks the format, 1 means short argument
	typedef enum logic [0:5] {
		LW  = 6'o01,
		TW  = 6'o02,
		RW  = 6'o03,
		AW  = 6'o04,
		SW  = 6'o05,
		NR  = 6'o06,
		OR  = 6'o07,
		ER  = 6'o10,
		AWT = 6'o41,
		UJS = 6'o42,
		JNS = 6'o43,
		HLT = 6'o44
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	typedef struct packed {
		opcode_t    opcode;
		logic       arg_sel; // 0 takes rc, 1 takes the next word
		logic [0:2] ra;
		logic [0:2] rb;      // base register, zero for none
		logic [0:2] rc;
	} norm_fmt_t;

	typedef struct packed {
		opcode_t    opcode;
		logic [0:2] ra;
		logic [0:6] t;       // two's complement
	} short_fmt_t;

	typedef union packed {
		norm_fmt_t  n;
		short_fmt_t s;
	} instr_t;

	// contents of r0
	typedef struct packed {
		logic        z;
		logic        m;
		logic        v;
		logic        c;
		logic [0:11] pad;
	} flags_t;

	typedef struct packed {
		alu_op_t alu;
		logic    need_arg; // second instruction word follows
		logic    mem_rd;
		logic    mem_wr;
		logic    wb_en;
		logic    jump;
		logic    cond;     // jump only while z is clear
		logic    halt;
	} ctl_t;

	typedef enum logic [2:0] {IDLE, FETCH, ARG, EXEC, MEM, HALT} mstate_t;

	typedef struct packed {
		word_t addr;
		word_t data;
		logic  rd;
		logic  wr;
	} bus_req_t;

	function automatic logic is_short(instr_t i);
		return i.s.opcode[0];
	endfunction

endpackage

// ==== hdl/cycle_ctl.sv ====
// machine-state sequencer
// idle, fetch, argument fetch, execute, memory access and halt,
// with the minimum state length, bus requests and the alarm latch

`include "cpu_cfg.svh"

module cycle_ctl (
	input  logic              __clk,
	input  logic              rst_n,
	input  logic              start,
	input  cpu_pkg::ctl_t     ctl,
	input  logic              bus_done,
	input  logic              nomem,
	input  cpu_pkg::flags_t   flags,
	input  cpu_pkg::word_t    ic,
	input  cpu_pkg::word_t    arg,
	input  cpu_pkg::word_t    a,
	output cpu_pkg::bus_req_t req,
	output logic              ld_ir,
	output logic              ld_arg,
	output logic              wb,
	output logic              ic_inc,
	output logic              ic_jump,
	output logic              ic_load,
	output logic              run,
	output logic              hlt,
	output logic              alarm
);
	import cpu_pkg::*;

	localparam int TICK_W = $clog2(`CPU_STATE_TICKS + 1);
	localparam logic [TICK_W-1:0] TICK_MIN = TICK_W'(`CPU_STATE_TICKS - 1);
	localparam logic [TICK_W-1:0] TICK_MAX = TICK_W'(`CPU_STATE_TICKS);

	mstate_t state, state_d;
	logic [TICK_W-1:0] tick; // clocks since state entry, saturating
	logic got;               // bus answered in this state
	logic stopped, bus_state, issue, min_ok, bus_end, exec_end, jump_ok;

	assign stopped   = (state == IDLE) || (state == HALT);
	assign bus_state = (state == FETCH) || (state == ARG) || (state == MEM);
	assign issue     = bus_state && (tick == '0); // one request per bus state
	assign min_ok    = tick >= TICK_MIN;
	assign bus_end   = min_ok && got;
	assign exec_end  = (state == EXEC) && min_ok && (tick != '0);
	assign jump_ok   = ctl.jump && (!ctl.cond || !flags.z);

	// ------------------------------------------------------------------------
	// next state

	always_comb begin
		state_d = state;
		case (state)
			IDLE, HALT: if (start) state_d = FETCH;
			FETCH:      if (bus_end) state_d = ctl.need_arg ? ARG : EXEC;
			ARG:        if (bus_end) state_d = EXEC;
			EXEC: if (exec_end) begin
				if (ctl.halt)
					state_d = HALT;
				else if (ctl.mem_rd || ctl.mem_wr)
					state_d = MEM;
				else
					state_d = FETCH;
			end
			MEM:        if (bus_end) state_d = FETCH;
			default:    state_d = IDLE;
		endcase
		if (nomem) state_d = IDLE; // bus alarm stops the machine
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= IDLE;
			tick  <= '0;
			got   <= 1'b0;
			alarm <= 1'b0;
		end else begin
			state <= state_d;
			if (state_d != state) begin
				tick <= '0;
				got  <= 1'b0;
			end else begin
				if (tick != TICK_MAX) tick <= tick + 1'b1;
				got <= got | bus_done;
			end
			if (nomem)
				alarm <= 1'b1;
			else if (ic_load)
				alarm <= 1'b0; // held until the next start
		end
	end

	// ------------------------------------------------------------------------
	// bus request and board strobes

	always_comb begin
		req.addr = (state == MEM) ? arg : ic; // ic for instruction words
		req.data = a;
		req.rd   = issue && ((state != MEM) || ctl.mem_rd);
		req.wr   = issue && (state == MEM) && ctl.mem_wr;
	end

	assign ld_ir   = (state == FETCH) && bus_done;
	assign ld_arg  = ((state == ARG) && bus_done) ||
	                 ((state == EXEC) && (tick == '0) && !ctl.need_arg);
	assign ic_inc  = ((state == FETCH) || (state == ARG)) && bus_done;
	assign ic_jump = exec_end && jump_ok;
	assign ic_load = stopped && start;
	assign wb      = ctl.wb_en && ((exec_end && !ctl.mem_rd) || ((state == MEM) && bus_done));

	assign run = !stopped;
	assign hlt = state == HALT;

endmodule

// ==== hdl/instr_decode.sv ====
// instruction register and decoder
// reads the latched word in the normal or the short format

module instr_decode (
	input  logic            __clk,
	input  logic            rst_n,
	input  logic            ld_ir,
	input  cpu_pkg::word_t  rdt,
	output cpu_pkg::instr_t ir,
	output cpu_pkg::ctl_t   ctl
);
	import cpu_pkg::*;

	always_ff @(posedge __clk) begin
		if (!rst_n)
			ir <= '0; // opcode 0 decodes as a halt
		else if (ld_ir)
			ir <= instr_t'(rdt);
	end

	// ------------------------------------------------------------------------
	// decoding, short group first

	always_comb begin
		ctl = '0;
		ctl.alu = ALU_PASS;
		if (is_short(ir)) begin
			case (ir.s.opcode)
				AWT: begin
					ctl.alu   = ALU_ADD;
					ctl.wb_en = 1'b1;
				end
				UJS: ctl.jump = 1'b1;
				JNS: begin
					ctl.jump = 1'b1;
					ctl.cond = 1'b1;
				end
				default: ctl.halt = 1'b1; // HLT and unused short codes
			endcase
		end else begin
			ctl.need_arg = ir.n.arg_sel; // only meaningful in this format
			case (ir.n.opcode)
				LW: ctl.wb_en = 1'b1;
				TW: begin
					ctl.mem_rd = 1'b1;
					ctl.wb_en  = 1'b1;
				end
				RW: ctl.mem_wr = 1'b1;
				AW: begin
					ctl.alu   = ALU_ADD;
					ctl.wb_en = 1'b1;
				end
				SW: begin
					ctl.alu   = ALU_SUB;
					ctl.wb_en = 1'b1;
				end
				NR: begin
					ctl.alu   = ALU_AND;
					ctl.wb_en = 1'b1;
				end
				OR: begin
					ctl.alu   = ALU_OR;
					ctl.wb_en = 1'b1;
				end
				ER: begin
					ctl.alu   = ALU_XOR;
					ctl.wb_en = 1'b1;
				end
				default: begin
					ctl.need_arg = 1'b0; // unknown code stops at once
					ctl.halt     = 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== hdl/reg_file.sv ====
// general registers r1..r7 and flag register r0
// three instruction read ports and the panel read port

`include "cpu_cfg.svh"

module reg_file (
	input  logic            __clk,
	input  logic            rst_n,
	input  logic            wb,
	input  cpu_pkg::instr_t ir,
	input  cpu_pkg::word_t  result,
	input  cpu_pkg::flags_t flags_in,
	input  logic [2:0]      rsel,
	output cpu_pkg::word_t  a,
	output cpu_pkg::word_t  b,
	output cpu_pkg::word_t  c,
	output cpu_pkg::word_t  w,
	output cpu_pkg::flags_t flags
);
	import cpu_pkg::*;

	word_t regs [1:`CPU_REGS-1];
	word_t view [0:`CPU_REGS-1]; // r0 seen as a word
	logic [2:0] ra_sel;

	always_comb begin
		view[0] = word_t'(flags);
		for (int i = 1; i < `CPU_REGS; i++)
			view[i] = regs[i];
	end

	assign ra_sel = is_short(ir) ? ir.s.ra : ir.n.ra; // ra sits apart in the two formats
	assign a = view[ra_sel];
	assign b = (ir.n.rb == 3'd0) ? '0 : view[ir.n.rb]; // no base
	assign c = view[ir.n.rc];
	assign w = view[rsel];

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			flags <= '0;
			for (int i = 1; i < `CPU_REGS; i++)
				regs[i] <= '0;
		end else if (wb) begin
			flags <= flags_in;
			if (ra_sel != 3'd0)
				regs[ra_sel] <= result;
		end
	end

endmodule

// ==== hdl/arith_unit.sv ====
// instruction counter, argument register and ALU
// result and z, m, v, c flags for the write-back

module arith_unit (
	input  logic            __clk,
	input  logic            rst_n,
	input  logic            ld_arg,
	input  logic            ic_inc,
	input  logic            ic_jump,
	input  logic            ic_load,
	input  cpu_pkg::word_t  kl,
	input  cpu_pkg::word_t  rdt,
	input  cpu_pkg::word_t  a,
	input  cpu_pkg::word_t  b,
	input  cpu_pkg::word_t  c,
	input  cpu_pkg::instr_t ir,
	input  cpu_pkg::ctl_t   ctl,
	output cpu_pkg::word_t  ic,
	output cpu_pkg::word_t  arg,
	output cpu_pkg::word_t  result,
	output cpu_pkg::flags_t flags_out
);
	import cpu_pkg::*;

	word_t t_ext, arg_d, alu_r;
	logic [0:16] sum, diff; // bit 0 is the carry out
	logic add_v, sub_v;

	// ------------------------------------------------------------------------
	// argument: short t, or rc / second word plus base

	assign t_ext = {{9{ir.s.t[0]}}, ir.s.t};
	assign arg_d = is_short(ir) ? t_ext : (ir.n.arg_sel ? rdt : c) + b;

	always_ff @(posedge __clk) begin
		if (ld_arg) arg <= arg_d;
	end

	always_ff @(posedge __clk) begin
		if (!rst_n)
			ic <= '0;
		else if (ic_load)
			ic <= kl;           // panel start address
		else if (ic_jump)
			ic <= ic + arg;     // relative to the next instruction
		else if (ic_inc)
			ic <= ic + 16'd1;
	end

	// ------------------------------------------------------------------------
	// ALU

	assign sum   = {1'b0, a} + {1'b0, arg};
	assign diff  = {1'b0, a} + {1'b0, ~arg} + 17'd1; // c set means no borrow
	assign add_v = (a[0] == arg[0]) && (sum[1] != a[0]);
	assign sub_v = (a[0] != arg[0]) && (diff[1] != a[0]);

	always_comb begin
		flags_out = '0;
		case (ctl.alu)
			ALU_ADD: begin
				alu_r       = sum[1:16];
				flags_out.c = sum[0];
				flags_out.v = add_v;
			end
			ALU_SUB: begin
				alu_r       = diff[1:16];
				flags_out.c = diff[0];
				flags_out.v = sub_v;
			end
			ALU_AND: alu_r = a & arg;
			ALU_OR:  alu_r = a | arg;
			ALU_XOR: alu_r = a ^ arg;
			default: alu_r = arg;
		endcase
		result      = ctl.mem_rd ? rdt : alu_r; // memory word for TW
		flags_out.z = result == '0;
		flags_out.m = result[0];
	end

endmodule

// ==== hdl/bus_ctl.sv ====
// memory bus strobe driver
// holds dr or dw until ok, returns the read word, and runs the
// no-answer alarm timer

`include "cpu_cfg.svh"

module bus_ctl (
	input  logic              __clk,
	input  logic              rst_n,
	input  cpu_pkg::bus_req_t req,
	input  logic              ok,
	input  cpu_pkg::word_t    rdt,
	output cpu_pkg::word_t    dad,
	output cpu_pkg::word_t    ddt,
	output logic              dr,
	output logic              dw,
	output logic              done,
	output logic              nomem,
	output cpu_pkg::word_t    rd_word
);

	localparam int CNT_W = $clog2(`CPU_ALARM_TICKS + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CPU_ALARM_TICKS - 1);

	logic [CNT_W-1:0] cnt; // clocks the strobe has been up
	logic strobe, take;

	assign strobe = dr | dw;
	assign take   = !strobe && (req.rd || req.wr);
	assign nomem  = strobe && !ok && (cnt == CNT_LAST);

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			dr   <= 1'b0;
			dw   <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			done <= strobe && ok;
			if (strobe) begin
				cnt <= cnt + 1'b1;
				if (ok || nomem) begin // strobe drops the next cycle
					dr <= 1'b0;
					dw <= 1'b0;
				end
			end else if (take) begin
				dr  <= req.rd;
				dw  <= req.wr && !req.rd; // never both
				cnt <= '0;
			end
		end
	end

	// address and data rise with the strobe and stay until it drops
	always_ff @(posedge __clk) begin
		if (take) begin
			dad <= req.addr;
			ddt <= req.data;
		end
		if (strobe && ok)
			rd_word <= rdt;
	end

endmodule

// ==== hdl/cpu.sv ====
// CPU top level
// sequencer, decoder, registers, arithmetic and bus boards joined to
// the control panel and the memory bus

module cpu (
	input  logic           __clk,
	input  logic           rst_n,
	input  logic           start,
	input  logic           ok,
	input  cpu_pkg::word_t kl,
	input  cpu_pkg::word_t rdt,
	input  logic [2:0]     rsel,
	output cpu_pkg::word_t w,
	output cpu_pkg::word_t dad,
	output cpu_pkg::word_t ddt,
	output logic           dr,
	output logic           dw,
	output logic           run,
	output logic           hlt,
	output logic           alarm
);
	import cpu_pkg::*;

	ctl_t     ctl;
	instr_t   ir;
	bus_req_t req;
	flags_t   flags, alu_flags;
	word_t    ic, arg, result, a, b, c, bus_rdt;
	logic     bus_done, nomem, ld_ir, ld_arg, wb, ic_inc, ic_jump, ic_load;

	// ------------------------------------------------------------------------
	// timing and decoding

	cycle_ctl u_cycle_ctl (
		.__clk(__clk), .rst_n(rst_n), .start(start), .ctl(ctl),
		.bus_done(bus_done), .nomem(nomem), .flags(flags),
		.ic(ic), .arg(arg), .a(a), .req(req),
		.ld_ir(ld_ir), .ld_arg(ld_arg), .wb(wb), .ic_inc(ic_inc),
		.ic_jump(ic_jump), .ic_load(ic_load),
		.run(run), .hlt(hlt), .alarm(alarm)
	);

	instr_decode u_instr_decode (
		.__clk(__clk), .rst_n(rst_n), .ld_ir(ld_ir), .rdt(bus_rdt),
		.ir(ir), .ctl(ctl)
	);

	// ------------------------------------------------------------------------
	// registers, arithmetic and bus

	reg_file u_reg_file (
		.__clk(__clk), .rst_n(rst_n), .wb(wb), .ir(ir), .result(result),
		.flags_in(alu_flags), .rsel(rsel),
		.a(a), .b(b), .c(c), .w(w), .flags(flags)
	);

	arith_unit u_arith_unit (
		.__clk(__clk), .rst_n(rst_n), .ld_arg(ld_arg), .ic_inc(ic_inc),
		.ic_jump(ic_jump), .ic_load(ic_load),
		.kl(kl), .rdt(bus_rdt), .a(a), .b(b), .c(c), .ir(ir), .ctl(ctl),
		.ic(ic), .arg(arg), .result(result), .flags_out(alu_flags)
	);

	bus_ctl u_bus_ctl (
		.__clk(__clk), .rst_n(rst_n), .req(req), .ok(ok), .rdt(rdt),
		.dad(dad), .ddt(ddt), .dr(dr), .dw(dw),
		.done(bus_done), .nomem(nomem), .rd_word(bus_rdt)
	);

endmodule

// ==== testbench/tb_cpu_checker.sv ====
// bus protocol assertions, bound to bus_ctl
// exclusive strobes, stable address, strobe release after ok, reset state

module tb_cpu_checker (
	input logic           clk,
	input logic           rst_n,
	input logic           dr,
	input logic           dw,
	input logic           ok,
	input cpu_pkg::word_t dad
);
	int fails = 0; // count of failed assertions

	a_excl: assert property (@(posedge clk) disable iff (!rst_n) !(dr && dw))
		else begin
			$error("dr and dw high together");
			fails++;
		end

	// address held for as long as the strobe stays up
	a_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(dr || dw) |=> !(dr || dw) || $stable(dad))
		else begin
			$error("dad changed under a strobe");
			fails++;
		end

	a_release: assert property (@(posedge clk) disable iff (!rst_n)
		(ok && (dr || dw)) |=> !(dr || dw))
		else begin
			$error("strobe still high after ok");
			fails++;
		end

	a_reset: assert property (@(posedge clk) !rst_n |=> (!dr && !dw))
		else begin
			$error("strobe high after reset");
			fails++;
		end

endmodule

bind bus_ctl tb_cpu_checker u_chk (
	.clk(__clk), .rst_n(rst_n), .dr(dr), .dw(dw), .ok(ok), .dad(dad)
);

// ==== testbench/tb_cpu.sv ====
// testbench for the cpu core
// clock, memory model with random ok delay, instruction reference model,
// directed and random programs, compare process and final report

`include "cpu_cfg.svh"

module tb_cpu;
	import cpu_pkg::*;

	localparam int MAX_INSTR = 40;
	localparam int N_TESTS = 25;
	localparam int CYCLE_LIMIT =
		(MAX_INSTR * 5 * (`CPU_STATE_TICKS + 4) + `CPU_ALARM_TICKS) * N_TESTS;
	localparam int ST_HALT = 0, ST_ALARM = 1, ST_LIMIT = 2;
	localparam int K_PASS = 0, K_ADD = 1, K_SUB = 2, K_AND = 3, K_OR = 4, K_XOR = 5;
	localparam logic [15:0] PROG_BASE = 16'h0020; // start address on the key switches

	logic clk, rst_n, start, ok, dr, dw, run, hlt, alarm;
	logic [2:0] rsel;
	word_t kl, rdt, w, dad, ddt;
	logic [15:0] bus_addr;

	word_t mem [0:255];
	logic [15:0] m_mem [0:255]; // model copy
	logic [15:0] m_r [1:7];
	flags_t m_fl;
	logic [31:0] rng = 32'h9042f1ac;
	int pa, exp_status, errors, failed_tests, test_no, cycles, busy, delay;
	event run_done, cmp_done;

	cpu u_dut (
		.__clk(clk), .rst_n(rst_n), .start(start), .ok(ok), .kl(kl), .rdt(rdt),
		.rsel(rsel), .w(w), .dad(dad), .ddt(ddt), .dr(dr), .dw(dw),
		.run(run), .hlt(hlt), .alarm(alarm)
	);

	assign bus_addr = dad;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] rand_next();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ------------------------------------------------------------------------
	// memory: ok 1 to 4 cycles after the strobe, nothing above 0x7fff

	always @(negedge clk) begin
		if (!rst_n) begin
			ok = 1'b0;
			busy = 0;
		end else if (ok) begin
			ok = 1'b0;
		end else if ((dr || dw) && !bus_addr[15]) begin
			if (busy == 0) begin
				busy = 1;
				delay = int'(rand_next() & 32'h3);
			end
			if (delay == 0) begin
				busy = 0;
				ok = 1'b1;
				if (dw)
					mem[bus_addr[7:0]] = ddt;
				else
					rdt = mem[bus_addr[7:0]];
			end else
				delay--;
		end
	end

	// ------------------------------------------------------------------------
	// reference model

	function automatic logic [15:0] reg_val(logic [2:0] i);
		return (i == 3'd0) ? 16'(m_fl) : m_r[i];
	endfunction

	function automatic flags_t alu_ref(input int kind, input logic [15:0] a, arg,
			output logic [15:0] r);
		logic [16:0] s;
		flags_t f;
		f = '0;
		case (kind)
			K_ADD: begin
				s = {1'b0, a} + {1'b0, arg};
				r = s[15:0];
				f.c = s[16];
				f.v = (a[15] == arg[15]) && (r[15] != a[15]);
			end
			K_SUB: begin
				s = {1'b0, a} + {1'b0, ~arg} + 17'd1; // carry set when no borrow
				r = s[15:0];
				f.c = s[16];
				f.v = (a[15] != arg[15]) && (r[15] != a[15]);
			end
			K_AND: r = a & arg;
			K_OR: r = a | arg;
			K_XOR: r = a ^ arg;
			default: r = arg;
		endcase
		f.z = r == 16'd0;
		f.m = r[15];
		return f;
	endfunction

	function automatic int run_model(logic [15:0] start_pc);
		logic [15:0] pc, iw, arg, a, res;
		logic [5:0] op;
		logic [2:0] ra, rb, rc;
		flags_t nf;
		pc = start_pc;
		for (int n = 0; n < MAX_INSTR; n++) begin
			iw = m_mem[pc[7:0]];
			pc = pc + 16'd1;
			op = iw[15:10];
			if (op[5]) begin // short argument group
				ra = iw[9:7];
				arg = {{9{iw[6]}}, iw[6:0]};
				if (op == AWT) begin
					nf = alu_ref(K_ADD, reg_val(ra), arg, res);
					m_fl = nf;
					if (ra != 3'd0) m_r[ra] = res;
				end else if (op == UJS)
					pc = pc + arg;
				else if (op == JNS) begin
					if (!m_fl.z) pc = pc + arg;
				end else
					return ST_HALT;
			end else begin
				ra = iw[8:6];
				rb = iw[5:3];
				rc = iw[2:0];
				if (!(op inside {LW, TW, RW, AW, SW, NR, OR, ER})) return ST_HALT;
				if (iw[9]) begin
					arg = m_mem[pc[7:0]];
					pc = pc + 16'd1;
				end else
					arg = reg_val(rc);
				if (rb != 3'd0) arg = arg + reg_val(rb);
				a = reg_val(ra);
				if ((op == TW || op == RW) && arg[15]) return ST_ALARM;
				if (op == RW)
					m_mem[arg[7:0]] = a;
				else begin
					case (op)
						TW: nf = alu_ref(K_PASS, a, m_mem[arg[7:0]], res);
						AW: nf = alu_ref(K_ADD, a, arg, res);
						SW: nf = alu_ref(K_SUB, a, arg, res);
						NR: nf = alu_ref(K_AND, a, arg, res);
						OR: nf = alu_ref(K_OR, a, arg, res);
						ER: nf = alu_ref(K_XOR, a, arg, res);
						default: nf = alu_ref(K_PASS, a, arg, res);
					endcase
					m_fl = nf;
					if (ra != 3'd0) m_r[ra] = res;
				end
			end
		end
		return ST_LIMIT;
	endfunction

	// ------------------------------------------------------------------------
	// compare tasks and the compare process

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flags(string name, flags_t got, flags_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is z%b m%b v%b c%b, expected z%b m%b v%b c%b",
				$time, name, got.z, got.m, got.v, got.c, exp.z, exp.m, exp.v, exp.c);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	initial begin
		forever begin
			@(run_done);
			for (int i = 0; i < 8; i++) begin
				@(negedge clk) rsel = 3'(i);
				@(posedge clk);
				if (i == 0)
					check_flags("r0", flags_t'(w), m_fl);
				else
					check_word($sformatf("r%0d", i), w, m_r[i]);
			end
			for (int i = 0; i < 256; i++)
				check_word($sformatf("mem[%0d]", i), mem[i], m_mem[i]);
			check_bit("hlt", hlt, exp_status == ST_HALT);
			check_bit("alarm", alarm, exp_status == ST_ALARM);
			check_bit("run", run, 1'b0);
			-> cmp_done;
		end
	end

	// ------------------------------------------------------------------------
	// program building and test runs

	function automatic word_t enc_n(opcode_t op, logic sel, logic [2:0] ra, rb, rc);
		return {op, sel, ra, rb, rc};
	endfunction

	function automatic word_t enc_s(opcode_t op, logic [2:0] ra, int t);
		return {op, ra, t[6:0]};
	endfunction

	task automatic new_prog();
		logic [7:0] ad;
		for (int i = 0; i < 256; i++) begin
			ad = 8'(i);
			mem[i] = {ad, ~ad} ^ 16'h3c5a;
		end
		pa = PROG_BASE;
	endtask

	task automatic put(word_t wd);
		mem[pa] = wd;
		pa++;
	endtask

	task automatic run_test(string name);
		int err0;
		err0 = errors;
		test_no++;
		for (int i = 0; i < 256; i++)
			m_mem[i] = mem[i];
		for (int i = 1; i < 8; i++)
			m_r[i] = '0;
		m_fl = '0;
		exp_status = run_model(PROG_BASE);
		@(negedge clk) rst_n = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		kl = PROG_BASE;
		start = 1'b1;
		@(negedge clk) start = 1'b0;
		check_bit("run", run, 1'b1); // up the cycle after start
		while (!(hlt || alarm)) @(negedge clk);
		-> run_done;
		@(cmp_done);
		if (errors == err0)
			$display("test %0d %s: ok", test_no, name);
		else begin
			$display("test %0d %s: %0d mismatches", test_no, name, errors - err0);
			failed_tests++;
		end
	endtask

	task automatic gen_random();
		logic [31:0] r;
		new_prog();
		for (int i = 1; i <= 3; i++) begin // seed values into r1..r3
			put(enc_n(LW, 1'b1, 3'(i), 3'd0, 3'd0));
			put(16'(rand_next()));
		end
		for (int i = 0; i < 9; i++) begin
			r = rand_next();
			case (r[31:16] % 7)
				0: put(enc_n(LW, r[3], r[6:4], r[9:7], r[12:10]));
				1: put(enc_n(AW, r[3], r[6:4], r[9:7], r[12:10]));
				2: put(enc_n(SW, r[3], r[6:4], r[9:7], r[12:10]));
				3: put(enc_n(NR, r[3], r[6:4], r[9:7], r[12:10]));
				4: put(enc_n(OR, r[3], r[6:4], r[9:7], r[12:10]));
				5: put(enc_n(ER, r[3], r[6:4], r[9:7], r[12:10]));
				default: put(enc_s(AWT, r[6:4], int'(r[22:16])));
			endcase
			if (r[3] && (r[31:16] % 7 != 6)) put(16'(rand_next())); // second word
		end
		put(enc_s(HLT, 3'd0, 0));
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		ok = 1'b0;
		kl = '0;
		rdt = '0;
		rsel = '0;
		errors = 0;
		failed_tests = 0;
		test_no = 0;

		new_prog(); // register ALU, ends on a signed overflow
		put(enc_n(LW, 1'b1, 3'd1, 3'd0, 3'd0));
		put(16'h7fff);
		put(enc_n(LW, 1'b1, 3'd2, 3'd0, 3'd0));
		put(16'h0001);
		put(enc_n(LW, 1'b0, 3'd3, 3'd0, 3'd1));
		put(enc_n(LW, 1'b0, 3'd4, 3'd0, 3'd1));
		put(enc_n(NR, 1'b0, 3'd4, 3'd0, 3'd2));
		put(enc_n(OR, 1'b0, 3'd5, 3'd0, 3'd1));
		put(enc_n(ER, 1'b0, 3'd5, 3'd0, 3'd2));
		put(enc_n(SW, 1'b0, 3'd6, 3'd0, 3'd2));
		put(enc_n(AW, 1'b0, 3'd3, 3'd0, 3'd2));
		put(enc_s(HLT, 3'd0, 0));
		run_test("register alu");

		new_prog(); // argument forms
		put(enc_n(LW, 1'b1, 3'd1, 3'd0, 3'd0));
		put(16'h0010);
		put(enc_n(LW, 1'b1, 3'd2, 3'd1, 3'd0));
		put(16'h0100);
		put(enc_n(LW, 1'b0, 3'd3, 3'd1, 3'd2));
		put(enc_s(AWT, 3'd3, -5));
		put(enc_s(AWT, 3'd4, 63));
		put(enc_s(AWT, 3'd1, -64));
		put(enc_s(HLT, 3'd0, 0));
		run_test("argument forms");

		new_prog(); // memory reads and writes
		put(enc_n(LW, 1'b1, 3'd1, 3'd0, 3'd0));
		put(16'h0080);
		put(enc_n(TW, 1'b0, 3'd2, 3'd0, 3'd1));
		put(enc_n(TW, 1'b1, 3'd3, 3'd1, 3'd0));
		put(16'h0004);
		put(enc_n(AW, 1'b0, 3'd2, 3'd0, 3'd3));
		put(enc_n(RW, 1'b1, 3'd2, 3'd0, 3'd0));
		put(16'h0090);
		put(enc_n(RW, 1'b1, 3'd3, 3'd1, 3'd0));
		put(16'h0011);
		put(enc_s(HLT, 3'd0, 0));
		run_test("memory");

		new_prog(); // countdown loop and a forward jump
		put(enc_n(LW, 1'b1, 3'd1, 3'd0, 3'd0));
		put(16'd5);
		put(enc_s(AWT, 3'd2, 3));
		put(enc_s(AWT, 3'd1, -1));
		put(enc_s(JNS, 3'd0, -3));
		put(enc_s(UJS, 3'd0, 1));
		put(enc_s(AWT, 3'd3, 1)); // skipped
		put(enc_s(AWT, 3'd4, 7));
		put(enc_s(HLT, 3'd0, 0));
		run_test("control flow");

		for (int i = 0; i < 20; i++) begin
			gen_random();
			run_test($sformatf("random %0d", i));
		end

		new_prog(); // load from an address nobody answers
		put(enc_n(LW, 1'b1, 3'd1, 3'd0, 3'd0));
		put(16'h1234);
		put(enc_s(AWT, 3'd2, 9));
		put(enc_n(TW, 1'b1, 3'd3, 3'd0, 3'd0));
		put(16'h8000);
		put(enc_s(AWT, 3'd4, 1));
		put(enc_s(HLT, 3'd0, 0));
		run_test("bus alarm");

		if (u_dut.u_bus_ctl.u_chk.fails != 0) begin
			$display("bus assertions failed %0d times", u_dut.u_bus_ctl.u_chk.fails);
			errors += u_dut.u_bus_ctl.u_chk.fails;
		end
		$display("tests %0d, failed %0d, errors %0d", test_no, failed_tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cycle_ctl.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/arith_unit.sv
hdl/bus_ctl.sv
hdl/cpu.sv
testbench/tb_cpu_checker.sv
testbench/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_pkg.sv
      - hdl/cycle_ctl.sv
      - hdl/instr_decode.sv
      - hdl/reg_file.sv
      - hdl/arith_unit.sv
      - hdl/bus_ctl.sv
      - hdl/cpu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_cpu_checker.sv
      - testbench/tb_cpu.sv
